//--- rtl/vseq_pkg.sv
/*
  Shared types and helpers for the vector sequencer front end.
  At most NrVInsn instructions are in flight, and each one is named by a 3-bit ID.
  vl must lie between 1 and 15. Register 0 doubles as the mask register.
*/
package vseq_pkg;

  // Number of instruction IDs in flight
  localparam int unsigned NrVInsn = 8;

  // Instruction ID and one-hot ID vectors
  typedef logic [2:0]         vid_t;
  typedef logic [NrVInsn-1:0] vid_mask_t;

  // Register index, vector length, scalar word
  typedef logic [4:0]  vreg_t;
  typedef logic [3:0]  vlen_t;
  typedef logic [31:0] scalar_t;

  // Supported vector operations
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VXOR   = 3'd2,
    VMAND  = 3'd3,
    VMOR   = 3'd4,
    VMPOPC = 3'd5,
    VLE    = 3'd6,
    VSE    = 3'd7
  } vseq_op_e;

  // Executing units
  typedef enum logic [1:0] {
    VFU_ALU   = 2'd0,
    VFU_LOAD  = 2'd1,
    VFU_STORE = 2'd2,
    VFU_MASK  = 2'd3
  } vfu_e;

  // Sequencer FSM
  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_WAIT = 1'b1
  } seq_state_e;

  // Unit that executes a given operation
  function automatic vfu_e op_to_vfu(vseq_op_e op);
    case (op)
      VADD, VSUB, VXOR:    return VFU_ALU;
      VMAND, VMOR, VMPOPC: return VFU_MASK;
      VLE:                 return VFU_LOAD;
      default:             return VFU_STORE;
    endcase
  endfunction

  function automatic logic is_load(vseq_op_e op);
    return op == VLE;
  endfunction

  function automatic logic is_store(vseq_op_e op);
    return op == VSE;
  endfunction

endpackage

//--- rtl/vseq_issue_if.sv
`timescale 1ns/1ps
/*
  Issue broadcast from the sequencer to every processing element.
  issue_valid is a one-cycle strobe, and the other issue fields are only
  meaningful while it is high. running is refreshed every cycle.
*/
interface vseq_issue_if;
  import vseq_pkg::*;

  logic      issue_valid;
  vid_t      issue_id;
  vseq_op_e  issue_op;
  vfu_e      issue_vfu;
  logic      issue_vm;
  vlen_t     issue_vl;
  scalar_t   issue_scalar;
  // OR of the RAW, WAR and WAW masks
  vid_mask_t hazard;
  // IDs still executing on some element
  vid_mask_t running;

  modport seq (
    output issue_valid, issue_id, issue_op, issue_vfu, issue_vm,
    output issue_vl, issue_scalar, hazard, running
  );

  modport pe (
    input issue_valid, issue_id, issue_op, issue_vfu, issue_vm,
    input issue_vl, issue_scalar, hazard, running
  );

endinterface

//--- rtl/vseq_sequencer.sv
`timescale 1ns/1ps
/*
  In-order issue with ID allocation and RAW/WAR/WAW hazard masks.
  Only the last reader and the last writer of each register are tracked.
  Loads, stores and instructions without vd hold the core until their
  acknowledge arrives. Element order is lanes, then load, store and mask.
*/
module vseq_sequencer #(
  parameter  int unsigned NrLanes = 2,
  localparam int unsigned NrPEs   = NrLanes + 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Dispatcher side
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  vseq_pkg::vseq_op_e                   req_op_i,
  input  vseq_pkg::vreg_t                      req_vd_i,
  input  vseq_pkg::vreg_t                      req_vs1_i,
  input  vseq_pkg::vreg_t                      req_vs2_i,
  input  logic                                 req_use_vd_i,
  input  logic                                 req_use_vs1_i,
  input  logic                                 req_use_vs2_i,
  input  logic                                 req_vm_i,
  input  vseq_pkg::vlen_t                      req_vl_i,
  input  vseq_pkg::scalar_t                    req_scalar_i,
  output logic                                 resp_valid_o,
  output logic                                 resp_error_o,
  output vseq_pkg::scalar_t                    resp_data_o,
  // Element side
  vseq_issue_if.seq                            issue,
  input  logic                   [NrPEs-1:0]   pe_ready_i,
  input  vseq_pkg::vid_mask_t    [NrPEs-1:0]   pe_done_i,
  input  logic                                 addr_ack_i,
  input  logic                                 addr_err_i,
  input  logic                                 scalar_valid_i,
  input  vseq_pkg::scalar_t                    scalar_data_i
);
  import vseq_pkg::*;

  // Element offsets after the lanes
  localparam int unsigned OffLoad  = 0;
  localparam int unsigned OffStore = 1;
  localparam int unsigned OffMask  = 2;
  localparam vreg_t       VMaskReg = '0;

  seq_state_e             state_d, state_q;
  // Per-element running matrix
  vid_mask_t  [NrPEs-1:0] pe_run_d, pe_run_q;
  vid_mask_t              running_d, running_q;
  // Running IDs minus those finishing this cycle
  vid_mask_t              live;
  vid_t                   next_id;
  logic                   full;
  logic                   accept, ack_now, wait_ldst, needs_wait;
  vfu_e                   req_vfu;

  // Last reader and last writer of each register
  logic       [31:0]      rd_valid_d, rd_valid_q, wr_valid_d, wr_valid_q;
  vid_t       [31:0]      rd_vid_d, rd_vid_q, wr_vid_d, wr_vid_q;
  vid_mask_t              raw, war, waw;

  // Registered issue broadcast
  logic                   issue_valid_q;
  vid_t                   issue_id_q;
  vseq_op_e               issue_op_q;
  vfu_e                   issue_vfu_q;
  logic                   issue_vm_q;
  vlen_t                  issue_vl_q;
  scalar_t                issue_scalar_q;
  vid_mask_t              hazard_d, hazard_q;

  // Lowest free ID, scanning down so the last hit wins
  always_comb begin : p_next_id
    next_id = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id = vid_t'(i);
    end
  end
  assign full = &running_q;

  always_comb begin : p_live
    live = '0;
    for (int p = 0; p < NrPEs; p++) begin
      live |= pe_run_q[p] & ~pe_done_i[p];
    end
  end

  // The pending core request is answered by address check or scalar result
  assign wait_ldst    = is_load(issue_op_q) || is_store(issue_op_q);
  assign ack_now      = (state_q == SEQ_WAIT) && (wait_ldst ? addr_ack_i : scalar_valid_i);
  assign resp_valid_o = ack_now;
  assign resp_error_o = ack_now && wait_ldst && addr_err_i;
  assign resp_data_o  = (ack_now && !wait_ldst) ? scalar_data_i : '0;

  // Ready may rise in the acknowledge cycle itself
  assign req_ready_o = ((state_q == SEQ_IDLE) || ack_now) && (&pe_ready_i) && !full;
  assign accept      = req_valid_i && req_ready_o;
  assign req_vfu     = op_to_vfu(req_op_i);
  assign needs_wait  = is_load(req_op_i) || is_store(req_op_i) || !req_use_vd_i;

  always_comb begin : p_seq
    state_d    = state_q;
    hazard_d   = hazard_q;
    raw        = '0;
    war        = '0;
    waw        = '0;
    rd_vid_d   = rd_vid_q;
    wr_vid_d   = wr_vid_q;
    // Retire finished IDs per element
    for (int p = 0; p < NrPEs; p++) begin
      pe_run_d[p] = pe_run_q[p] & ~pe_done_i[p];
    end
    // Drop list entries whose ID has left running
    for (int v = 0; v < 32; v++) begin
      rd_valid_d[v] = rd_valid_q[v] & running_q[rd_vid_q[v]];
      wr_valid_d[v] = wr_valid_q[v] & running_q[wr_vid_q[v]];
    end

    if (state_q == SEQ_WAIT) hazard_d = hazard_q & live;
    if (ack_now) state_d = SEQ_IDLE;

    if (accept) begin
      case (req_vfu)
        VFU_LOAD:  pe_run_d[NrLanes + OffLoad][next_id]  = 1'b1;
        VFU_STORE: pe_run_d[NrLanes + OffStore][next_id] = 1'b1;
        VFU_MASK:  pe_run_d[NrLanes + OffMask][next_id]  = 1'b1;
        default: begin
          for (int l = 0; l < NrLanes; l++) begin
            pe_run_d[l][next_id] = 1'b1;
          end
        end
      endcase
      // Masked instructions also occupy the mask unit
      if (!req_vm_i) pe_run_d[NrLanes + OffMask][next_id] = 1'b1;

      // RAW against the last writer of each source
      if (req_use_vs1_i && wr_valid_d[req_vs1_i]) raw[wr_vid_d[req_vs1_i]] = 1'b1;
      if (req_use_vs2_i && wr_valid_d[req_vs2_i]) raw[wr_vid_d[req_vs2_i]] = 1'b1;
      if (!req_vm_i && wr_valid_d[VMaskReg]) raw[wr_vid_d[VMaskReg]] = 1'b1;

      // WAR and WAW on the destination
      if (req_use_vd_i) begin
        if (rd_valid_d[req_vd_i]) war[rd_vid_d[req_vd_i]] = 1'b1;
        if (wr_valid_d[req_vd_i]) waw[wr_vid_d[req_vd_i]] = 1'b1;
        wr_valid_d[req_vd_i] = 1'b1;
        wr_vid_d[req_vd_i]   = next_id;
      end

      // Record the new reader after hazards are taken
      if (req_use_vs1_i) begin
        rd_valid_d[req_vs1_i] = 1'b1;
        rd_vid_d[req_vs1_i]   = next_id;
      end
      if (req_use_vs2_i) begin
        rd_valid_d[req_vs2_i] = 1'b1;
        rd_vid_d[req_vs2_i]   = next_id;
      end
      if (!req_vm_i) begin
        rd_valid_d[VMaskReg] = 1'b1;
        rd_vid_d[VMaskReg]   = next_id;
      end

      // IDs finishing now must not reach the elements
      hazard_d = (raw | war | waw) & live;
      if (needs_wait) state_d = SEQ_WAIT;
    end
  end

  always_comb begin : p_running
    running_d = '0;
    for (int p = 0; p < NrPEs; p++) begin
      running_d |= pe_run_d[p];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      state_q       <= SEQ_IDLE;
      pe_run_q      <= '0;
      running_q     <= '0;
      rd_valid_q    <= '0;
      wr_valid_q    <= '0;
      issue_valid_q <= 1'b0;
      hazard_q      <= '0;
    end else begin
      state_q       <= state_d;
      pe_run_q      <= pe_run_d;
      running_q     <= running_d;
      rd_valid_q    <= rd_valid_d;
      wr_valid_q    <= wr_valid_d;
      issue_valid_q <= accept;
      hazard_q      <= hazard_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload_ff
    rd_vid_q <= rd_vid_d;
    wr_vid_q <= wr_vid_d;
    if (accept) begin
      issue_id_q     <= next_id;
      issue_op_q     <= req_op_i;
      issue_vfu_q    <= req_vfu;
      issue_vm_q     <= req_vm_i;
      issue_vl_q     <= req_vl_i;
      issue_scalar_q <= req_scalar_i;
    end
  end

  assign issue.issue_valid  = issue_valid_q;
  assign issue.issue_id     = issue_id_q;
  assign issue.issue_op     = issue_op_q;
  assign issue.issue_vfu    = issue_vfu_q;
  assign issue.issue_vm     = issue_vm_q;
  assign issue.issue_vl     = issue_vl_q;
  assign issue.issue_scalar = issue_scalar_q;
  assign issue.hazard       = hazard_q;
  assign issue.running      = running_q;

endmodule

//--- rtl/vseq_pe.sv
`timescale 1ns/1ps
/*
  Timing model of one processing element, with no datapath.
  Holds one pending instruction plus the one being executed.
  A lane runs ceil(vl/NrLanes) cycles, other units run vl cycles.
*/
module vseq_pe #(
  parameter vseq_pkg::vfu_e UNIT    = vseq_pkg::VFU_ALU,
  parameter int unsigned    NrLanes = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  vseq_issue_if.pe            issue,
  output logic                ready_o,
  output vseq_pkg::vid_mask_t done_o,
  output logic                addr_ack_o,
  output logic                addr_err_o,
  output logic                scalar_valid_o,
  output vseq_pkg::scalar_t   scalar_data_o
);
  import vseq_pkg::*;

  logic      mine, capture, start;
  vlen_t     len_in;

  // Pending slot
  logic      pend_q;
  vid_t      pend_id_q;
  vseq_op_e  pend_op_q;
  vlen_t     pend_len_q;
  scalar_t   pend_scalar_q;
  vid_mask_t pend_haz_q;

  // Run stage after the first cycle
  logic      run_q;
  vid_t      run_id_q;
  vseq_op_e  run_op_q;
  vlen_t     run_left_q;
  scalar_t   run_scalar_q;

  // Instruction executing this cycle
  logic      cur_valid, cur_last;
  vid_t      cur_id;
  vseq_op_e  cur_op;
  vlen_t     cur_left;
  scalar_t   cur_scalar;

  // Mask unit also takes every masked instruction
  assign mine    = (issue.issue_vfu == UNIT) || ((UNIT == VFU_MASK) && !issue.issue_vm);
  assign capture = issue.issue_valid && mine;

  always_comb begin : p_len
    if (UNIT == VFU_ALU) len_in = vlen_t'((32'(issue.issue_vl) + NrLanes - 1) / NrLanes);
    else len_in = issue.issue_vl;
  end

  // First run cycle is the first one with all hazard IDs retired
  assign start   = pend_q && !run_q && ((pend_haz_q & issue.running) == '0);
  assign ready_o = (!pend_q || start) && !capture;

  assign cur_valid  = start || run_q;
  assign cur_id     = start ? pend_id_q : run_id_q;
  assign cur_op     = start ? pend_op_q : run_op_q;
  assign cur_left   = start ? pend_len_q : run_left_q;
  assign cur_scalar = start ? pend_scalar_q : run_scalar_q;
  assign cur_last   = cur_valid && (cur_left == vlen_t'(1));

  always_comb begin : p_done
    done_o = '0;
    if (cur_last) done_o[cur_id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      pend_q     <= 1'b0;
      pend_haz_q <= '0;
      run_q      <= 1'b0;
    end else begin
      if (capture) pend_q <= 1'b1;
      else if (start) pend_q <= 1'b0;
      // Retired IDs are pruned so a reused ID cannot stall this slot
      if (capture) pend_haz_q <= issue.hazard;
      else pend_haz_q <= pend_haz_q & issue.running;
      if (start && !cur_last) run_q <= 1'b1;
      else if (run_q && cur_last) run_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload_ff
    if (capture) begin
      pend_id_q     <= issue.issue_id;
      pend_op_q     <= issue.issue_op;
      pend_len_q    <= len_in;
      pend_scalar_q <= issue.issue_scalar;
    end
    if (start) begin
      run_id_q     <= pend_id_q;
      run_op_q     <= pend_op_q;
      run_scalar_q <= pend_scalar_q;
      run_left_q   <= pend_len_q - vlen_t'(1);
    end else if (run_q) begin
      run_left_q <= run_left_q - vlen_t'(1);
    end
  end

  // Address check in the first run cycle
  if (UNIT == VFU_LOAD || UNIT == VFU_STORE) begin : g_addr
    assign addr_ack_o = start;
    assign addr_err_o = start && (pend_scalar_q[1:0] != 2'b00);
  end else begin : g_no_addr
    assign addr_ack_o = 1'b0;
    assign addr_err_o = 1'b0;
  end

  // Popcount result in the last run cycle
  if (UNIT == VFU_MASK) begin : g_popc
    assign scalar_valid_o = cur_last && (cur_op == VMPOPC);
    assign scalar_data_o  = scalar_valid_o ? scalar_t'($countones(cur_scalar)) : '0;
  end else begin : g_no_popc
    assign scalar_valid_o = 1'b0;
    assign scalar_data_o  = '0;
  end

endmodule

//--- rtl/vseq_top.sv
`timescale 1ns/1ps
/*
  Vector front end: sequencer, NrLanes ALU lanes, load, store and mask units.
  Dispatcher fields must stay stable while req_valid_i waits for ready.
  The load and store address acknowledges are merged here.
*/
module vseq_top #(
  parameter int unsigned NrLanes = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vseq_pkg::vseq_op_e req_op_i,
  input  vseq_pkg::vreg_t    req_vd_i,
  input  vseq_pkg::vreg_t    req_vs1_i,
  input  vseq_pkg::vreg_t    req_vs2_i,
  input  logic               req_use_vd_i,
  input  logic               req_use_vs1_i,
  input  logic               req_use_vs2_i,
  input  logic               req_vm_i,
  input  vseq_pkg::vlen_t    req_vl_i,
  input  vseq_pkg::scalar_t  req_scalar_i,
  output logic               resp_valid_o,
  output logic               resp_error_o,
  output vseq_pkg::scalar_t  resp_data_o,
  // Observation of the issue stream
  output vseq_pkg::vid_mask_t running_o,
  output logic               issue_valid_o,
  output vseq_pkg::vid_t     issue_id_o
);
  import vseq_pkg::*;

  localparam int unsigned NrPEs = NrLanes + 3;

  vseq_issue_if u_issue_if ();

  logic      [NrPEs-1:0] pe_ready;
  vid_mask_t [NrPEs-1:0] pe_done;
  logic                  ld_ack, ld_err, st_ack, st_err;
  logic                  scalar_valid;
  scalar_t               scalar_data;

  vseq_sequencer #(
    .NrLanes(NrLanes)
  ) u_sequencer (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_op_i,
    .req_vd_i, .req_vs1_i, .req_vs2_i,
    .req_use_vd_i, .req_use_vs1_i, .req_use_vs2_i, .req_vm_i,
    .req_vl_i, .req_scalar_i,
    .resp_valid_o, .resp_error_o, .resp_data_o,
    .issue          (u_issue_if.seq),
    .pe_ready_i     (pe_ready),
    .pe_done_i      (pe_done),
    .addr_ack_i     (ld_ack | st_ack),
    .addr_err_i     ((ld_ack & ld_err) | (st_ack & st_err)),
    .scalar_valid_i (scalar_valid),
    .scalar_data_i  (scalar_data)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    vseq_pe #(.UNIT(VFU_ALU), .NrLanes(NrLanes)) u_lane (
      .clk_i, .rst_ni, .issue(u_issue_if.pe),
      .ready_o(pe_ready[l]), .done_o(pe_done[l]),
      .addr_ack_o(), .addr_err_o(), .scalar_valid_o(), .scalar_data_o()
    );
  end

  vseq_pe #(.UNIT(VFU_LOAD), .NrLanes(NrLanes)) u_load (
    .clk_i, .rst_ni, .issue(u_issue_if.pe),
    .ready_o(pe_ready[NrLanes]), .done_o(pe_done[NrLanes]),
    .addr_ack_o(ld_ack), .addr_err_o(ld_err), .scalar_valid_o(), .scalar_data_o()
  );

  vseq_pe #(.UNIT(VFU_STORE), .NrLanes(NrLanes)) u_store (
    .clk_i, .rst_ni, .issue(u_issue_if.pe),
    .ready_o(pe_ready[NrLanes+1]), .done_o(pe_done[NrLanes+1]),
    .addr_ack_o(st_ack), .addr_err_o(st_err), .scalar_valid_o(), .scalar_data_o()
  );

  // Mask unit also serves every masked instruction
  vseq_pe #(.UNIT(VFU_MASK), .NrLanes(NrLanes)) u_mask (
    .clk_i, .rst_ni, .issue(u_issue_if.pe),
    .ready_o(pe_ready[NrLanes+2]), .done_o(pe_done[NrLanes+2]),
    .addr_ack_o(), .addr_err_o(),
    .scalar_valid_o(scalar_valid), .scalar_data_o(scalar_data)
  );

  assign running_o     = u_issue_if.running;
  assign issue_valid_o = u_issue_if.issue_valid;
  assign issue_id_o    = u_issue_if.issue_id;

endmodule

//--- dv/vseq_properties.sv
`timescale 1ns/1ps
/*
  Concurrent checks on the vseq_top ports, attached with bind.
  Failures are also counted in fail_count for the testbench summary.
*/
module vseq_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_valid_i,
  input logic                req_ready_o,
  input vseq_pkg::vseq_op_e  req_op_i,
  input vseq_pkg::vreg_t     req_vd_i,
  input vseq_pkg::vreg_t     req_vs1_i,
  input vseq_pkg::vreg_t     req_vs2_i,
  input vseq_pkg::vlen_t     req_vl_i,
  input vseq_pkg::scalar_t   req_scalar_i,
  input logic                resp_valid_o,
  input vseq_pkg::vid_mask_t running_o,
  input logic                issue_valid_o,
  input vseq_pkg::vid_t      issue_id_o
);
  import vseq_pkg::*;

  int unsigned fail_count = 0;
  logic        accept;

  assign accept = req_valid_i && req_ready_o;

  // Lowest ID not yet running
  function automatic vid_t lowest_free(vid_mask_t run);
    vid_t id;
    id = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!run[i]) id = vid_t'(i);
    end
    return id;
  endfunction

  // Quiet outputs and ready while in reset
  a_reset_state: assert property (@(posedge clk_i)
    !rst_ni |-> (!resp_valid_o && !issue_valid_o && running_o == '0 && req_ready_o))
    else begin fail_count++; $error("Outputs not idle during reset"); end

  // Issue one cycle after acceptance, with the lowest free ID now running
  a_issue_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> (issue_valid_o && issue_id_o == $past(lowest_free(running_o))
                && running_o[issue_id_o]))
    else begin fail_count++; $error("Issue missing or wrong after acceptance"); end

  a_issue_only_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> $past(accept))
    else begin fail_count++; $error("Issue strobe without acceptance"); end

  // No free ID means no acceptance
  a_full_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&running_o) |-> !req_ready_o)
    else begin fail_count++; $error("Ready high with all IDs in flight"); end

  // Dispatcher holds its request until accepted
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !req_ready_o) |=> (req_valid_i &&
      $stable({req_op_i, req_vd_i, req_vs1_i, req_vs2_i, req_vl_i, req_scalar_i})))
    else begin fail_count++; $error("Request changed before acceptance"); end

endmodule

bind vseq_top vseq_properties u_props (.*);

//--- dv/tb_vseq.sv
`timescale 1ns/1ps
/*
  Directed then random stimulus for vseq_top with NrLanes = 2.
  Responses, issue IDs and retire order are checked against a local model.
*/
module tb_vseq;
  import vseq_pkg::*;

  localparam int unsigned NrRandom = 200;
  localparam int unsigned MaxCycles = NrRandom * 40 + 500;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_valid_i = 1'b0, req_use_vd_i = 1'b0, req_use_vs1_i = 1'b0;
  logic req_use_vs2_i = 1'b0, req_vm_i = 1'b1;
  vseq_op_e req_op_i = VADD;
  vreg_t req_vd_i = '0, req_vs1_i = '0, req_vs2_i = '0;
  vlen_t req_vl_i = 4'd1;
  scalar_t req_scalar_i = '0;
  logic req_ready_o, resp_valid_o, resp_error_o, issue_valid_o;
  scalar_t resp_data_o;
  vid_mask_t running_o;
  vid_t issue_id_o;

  int errors = 0;
  int cycles = 0;
  int seed = 32'h63c3_d638;

  // Reference model state
  logic [31:0] wr_v = '0, rd_v = '0;
  vid_t wr_id [32];
  vid_t rd_id [32];
  vid_mask_t deps [NrVInsn];
  vid_mask_t prev_run = '0;
  logic issue_due = 1'b0, resp_due = 1'b0, resp_ldst = 1'b0, resp_err = 1'b0;
  vid_t exp_id = '0;
  scalar_t resp_data = '0;

  vseq_top #(.NrLanes(2)) u_vseq_top (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MaxCycles) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic scalar_t count_bits(scalar_t v);
    scalar_t n;
    n = '0;
    for (int i = 0; i < 32; i++) n += scalar_t'(v[i]);
    return n;
  endfunction

  // Sample at the falling edge where every output is settled
  always @(negedge clk_i) begin : monitor
    vid_mask_t fell;
    vid_mask_t hz;
    vid_t nid;
    if (rst_ni) begin
      fell = prev_run & ~running_o;
      for (int i = 0; i < NrVInsn; i++) begin
        if (fell[i]) begin
          assert (deps[i] == '0) else begin
            errors++;
            $display("ID %0d retired before its producers (%b) at %0t", i, deps[i], $time);
          end
        end
      end
      // Retired IDs no longer create hazards
      for (int i = 0; i < NrVInsn; i++) deps[i] &= ~fell;
      for (int r = 0; r < 32; r++) begin
        if (fell[wr_id[r]]) wr_v[r] = 1'b0;
        if (fell[rd_id[r]]) rd_v[r] = 1'b0;
      end
      if (issue_due) begin
        assert (issue_valid_o && issue_id_o == exp_id) else begin
          errors++;
          $display("Mismatch at %0t: issue_id_o got %0d expected %0d (valid %b)",
                   $time, issue_id_o, exp_id, issue_valid_o);
        end
      end
      issue_due = 1'b0;
      if (resp_valid_o) begin
        assert (resp_due) else begin
          errors++;
          $display("Response without a pending request at %0t", $time);
        end
        if (resp_ldst) begin
          assert (resp_error_o == resp_err) else begin
            errors++;
            $display("Mismatch at %0t: resp_error_o got %b expected %b",
                     $time, resp_error_o, resp_err);
          end
        end else begin
          assert (resp_data_o == resp_data) else begin
            errors++;
            $display("Mismatch at %0t: resp_data_o got %0d expected %0d",
                     $time, resp_data_o, resp_data);
          end
        end
        resp_due = 1'b0;
      end
      if (req_valid_i && req_ready_o) begin
        assert (!resp_due) else begin
          errors++;
          $display("Second instruction accepted before the response at %0t", $time);
        end
        nid = '0;
        for (int i = NrVInsn - 1; i >= 0; i--) if (!running_o[i]) nid = vid_t'(i);
        hz = '0;
        if (req_use_vs1_i && wr_v[req_vs1_i]) hz[wr_id[req_vs1_i]] = 1'b1;
        if (req_use_vs2_i && wr_v[req_vs2_i]) hz[wr_id[req_vs2_i]] = 1'b1;
        if (!req_vm_i && wr_v[0]) hz[wr_id[0]] = 1'b1;
        if (req_use_vd_i) begin
          if (rd_v[req_vd_i]) hz[rd_id[req_vd_i]] = 1'b1;
          if (wr_v[req_vd_i]) hz[wr_id[req_vd_i]] = 1'b1;
          wr_v[req_vd_i] = 1'b1;
          wr_id[req_vd_i] = nid;
        end
        if (req_use_vs1_i) begin
          rd_v[req_vs1_i] = 1'b1;
          rd_id[req_vs1_i] = nid;
        end
        if (req_use_vs2_i) begin
          rd_v[req_vs2_i] = 1'b1;
          rd_id[req_vs2_i] = nid;
        end
        if (!req_vm_i) begin
          rd_v[0] = 1'b1;
          rd_id[0] = nid;
        end
        deps[nid] = hz;
        exp_id = nid;
        issue_due = 1'b1;
        resp_ldst = (req_op_i == VLE) || (req_op_i == VSE);
        resp_due = resp_ldst || !req_use_vd_i;
        resp_err = req_scalar_i[1:0] != 2'b00;
        resp_data = count_bits(req_scalar_i);
      end
      prev_run = running_o;
    end
  end

  // Present one instruction and hold it until the sequencer takes it
  task automatic send(vseq_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, logic use_vs,
                      logic vm, vlen_t vl, scalar_t sc);
    req_op_i = op;
    req_vd_i = vd;
    req_vs1_i = vs1;
    req_vs2_i = vs2;
    req_use_vd_i = !(op == VSE || op == VMPOPC);
    req_use_vs1_i = use_vs && op != VLE;
    req_use_vs2_i = use_vs && op != VLE;
    req_vm_i = vm;
    req_vl_i = vl;
    req_scalar_i = sc;
    req_valid_i = 1'b1;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1 req_valid_i = 1'b0;
  endtask

  initial begin
    vseq_op_e op;
    for (int i = 0; i < NrVInsn; i++) deps[i] = '0;
    for (int r = 0; r < 32; r++) begin
      wr_id[r] = '0;
      rd_id[r] = '0;
    end
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    // Address checks and popcount
    send(VLE, 5'd1, 5'd0, 5'd0, 1'b0, 1'b1, 4'd3, 32'h0000_1002);
    send(VLE, 5'd2, 5'd0, 5'd0, 1'b0, 1'b1, 4'd3, 32'h0000_1000);
    send(VSE, 5'd0, 5'd2, 5'd2, 1'b1, 1'b1, 4'd2, 32'h0000_2000);
    send(VMPOPC, 5'd0, 5'd1, 5'd1, 1'b1, 1'b1, 4'd4, 32'hf0f0_1234);
    // RAW pair, long producer on the mask unit and short consumer on the lanes
    send(VMAND, 5'd3, 5'd5, 5'd6, 1'b1, 1'b1, 4'd15, '0);
    send(VADD, 5'd4, 5'd3, 5'd3, 1'b1, 1'b1, 4'd1, '0);
    // WAW pair, long writer on the lanes and short writer on the mask unit
    send(VSUB, 5'd7, 5'd1, 5'd2, 1'b1, 1'b1, 4'd15, '0);
    send(VMOR, 5'd7, 5'd1, 5'd2, 1'b1, 1'b1, 4'd1, '0);
    // WAR pair, long reader on the mask unit and short writer on the lanes
    send(VMAND, 5'd8, 5'd9, 5'd9, 1'b1, 1'b1, 4'd15, '0);
    send(VXOR, 5'd9, 5'd1, 5'd2, 1'b1, 1'b1, 4'd1, '0);
    // Independent work alternating between lanes and mask unit
    for (int i = 0; i < 10; i++) begin
      send(i[0] ? VMOR : VADD, vreg_t'(8 + i), 5'd20, 5'd21, 1'b1, 1'b1, 4'd15, '0);
    end
    for (int n = 0; n < NrRandom; n++) begin
      op = vseq_op_e'($random(seed) & 7);
      send(op, vreg_t'($random(seed) & 7), vreg_t'($random(seed) & 7),
           vreg_t'($random(seed) & 7), 1'b1, $random(seed) % 4 != 0,
           vlen_t'({$random(seed)} % 15 + 1), $random(seed));
    end
    while (running_o != '0 || resp_due) @(negedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("Model check errors: %0d, assertion failures: %0d",
             errors, u_vseq_top.u_props.fail_count);
    if (errors == 0 && u_vseq_top.u_props.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/vseq_pkg.sv
rtl/vseq_issue_if.sv
rtl/vseq_sequencer.sv
rtl/vseq_pe.sv
rtl/vseq_top.sv
dv/vseq_properties.sv
dv/tb_vseq.sv

//--- Makefile
# Verilator flow for the vector sequencer front end
SHELL      := /bin/bash
VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= tb_vseq
RTL_TOP    ?= vseq_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Errors found
VFLAGS     ?= --timing --assert -Wall
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
	  --Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	set -o pipefail; ./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
